//--- verilog/core_pkg.sv
`default_nettype none

package core_pkg;

    localparam int xlen = 32;

    typedef logic [xlen-1:0] word_t;
    typedef logic [4:0]      reg_addr_t;

    typedef enum logic [2:0] {
        alu_add,
        alu_sub,
        alu_slt,
        alu_and,
        alu_or,
        alu_xor,
        alu_pass_b
    } alu_op_t;

    // 3R class, matched on bits 31:15
    localparam logic [16:0] op_add_w = 17'h00020;
    localparam logic [16:0] op_sub_w = 17'h00022;
    localparam logic [16:0] op_slt   = 17'h00024;
    localparam logic [16:0] op_and   = 17'h00029;
    localparam logic [16:0] op_or    = 17'h0002a;
    localparam logic [16:0] op_xor   = 17'h0002b;
    // immediate and branch classes
    localparam logic [9:0]  op_addi_w  = 10'h00a;
    localparam logic [6:0]  op_lu12i_w = 7'h0a;
    localparam logic [5:0]  op_beq     = 6'h16;
    localparam logic [5:0]  op_bne     = 6'h17;

    typedef struct packed {
        word_t     pc;
        word_t     a;
        word_t     b;
        word_t     imm;
        logic      use_imm;
        alu_op_t   alu_op;
        logic      branch;
        logic      br_ne;
        reg_addr_t rd;
        logic      wr;
    } dec_pkt_t;

    typedef struct packed {
        word_t     pc;
        reg_addr_t rd;
        logic      wr;
        word_t     result;
    } res_pkt_t;

endpackage : core_pkg

`default_nettype wire

//--- verilog/inst_fetch.sv
`timescale 1ns/100ps
`default_nettype none

module inst_fetch #(
    parameter core_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  wire                  clk,
    input  wire                  rst,
    input  wire                  flush,
    input  wire core_pkg::word_t redirect_pc,
    input  wire                  iram_valid,
    output logic                 iram_en,
    output core_pkg::word_t      iram_addr,
    output logic                 fetch_valid,
    output core_pkg::word_t      fetch_pc
);

    core_pkg::word_t pc;

    // redirect wins over a normal advance
    always_ff @(posedge clk) begin
        if (rst) begin
            pc <= RESET_PC;
        end else if (flush) begin
            pc <= redirect_pc;
        end else if (iram_valid) begin
            pc <= pc + 32'd4;
        end
    end

    // no request while the pc is being redirected
    assign iram_en   = !flush;
    assign iram_addr = pc;

    // word returned in the flush cycle belongs to the wrong path
    assign fetch_valid = iram_valid && !flush;
    assign fetch_pc    = pc;

    addr_aligned: assert property (@(posedge clk) disable iff (rst)
        iram_addr[1:0] == 2'b00);

endmodule : inst_fetch

`default_nettype wire

//--- verilog/operand_bypass.sv
`timescale 1ns/100ps
`default_nettype none

module operand_bypass (
    input  wire core_pkg::reg_addr_t src,
    input  wire core_pkg::word_t     rf_data,
    input  wire                      ex_valid,
    input  wire core_pkg::reg_addr_t ex_rd,
    input  wire core_pkg::word_t     ex_result,
    input  wire                      wb_valid,
    input  wire core_pkg::reg_addr_t wb_rd,
    input  wire core_pkg::word_t     wb_result,
    output core_pkg::word_t          operand
);

    logic hit_ex;
    logic hit_wb;

    // r0 is never forwarded
    assign hit_ex = ex_valid && (ex_rd == src) && (src != 5'd0);
    assign hit_wb = wb_valid && (wb_rd == src) && (src != 5'd0);

    // youngest producer first
    always_comb begin
        if (hit_ex) begin
            operand = ex_result;
        end else if (hit_wb) begin
            operand = wb_result;
        end else begin
            operand = rf_data;
        end
    end

endmodule : operand_bypass

`default_nettype wire

//--- verilog/inst_decode.sv
`timescale 1ns/100ps
`default_nettype none

module inst_decode (
    input  wire core_pkg::word_t     inst,
    input  wire core_pkg::word_t     pc,
    input  wire                      inst_valid,
    output core_pkg::reg_addr_t      rf_raddr1,
    output core_pkg::reg_addr_t      rf_raddr2,
    input  wire core_pkg::word_t     rf_rdata1,
    input  wire core_pkg::word_t     rf_rdata2,
    input  wire                      ex_valid,
    input  wire core_pkg::reg_addr_t ex_rd,
    input  wire core_pkg::word_t     ex_result,
    input  wire                      wb_valid,
    input  wire core_pkg::reg_addr_t wb_rd,
    input  wire core_pkg::word_t     wb_result,
    output core_pkg::dec_pkt_t       dec
);

    core_pkg::word_t   opnd_a;
    core_pkg::word_t   opnd_b;
    core_pkg::alu_op_t op_3r;
    logic              is_3r;
    logic              is_addi;
    logic              is_lu12i;
    logic              is_branch;

    assign is_addi   = inst[31:22] == core_pkg::op_addi_w;
    assign is_lu12i  = inst[31:25] == core_pkg::op_lu12i_w;
    assign is_branch = (inst[31:26] == core_pkg::op_beq) || (inst[31:26] == core_pkg::op_bne);

    // branches compare rj with rd
    assign rf_raddr1 = inst[9:5];
    assign rf_raddr2 = is_branch ? inst[4:0] : inst[14:10];

    operand_bypass bypass_a (
        .src(rf_raddr1), .rf_data(rf_rdata1),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_result(wb_result),
        .operand(opnd_a)
    );

    operand_bypass bypass_b (
        .src(rf_raddr2), .rf_data(rf_rdata2),
        .ex_valid(ex_valid), .ex_rd(ex_rd), .ex_result(ex_result),
        .wb_valid(wb_valid), .wb_rd(wb_rd), .wb_result(wb_result),
        .operand(opnd_b)
    );

    always_comb begin
        is_3r = 1'b1;
        op_3r = core_pkg::alu_add;
        case (inst[31:15])
            core_pkg::op_add_w: op_3r = core_pkg::alu_add;
            core_pkg::op_sub_w: op_3r = core_pkg::alu_sub;
            core_pkg::op_slt:   op_3r = core_pkg::alu_slt;
            core_pkg::op_and:   op_3r = core_pkg::alu_and;
            core_pkg::op_or:    op_3r = core_pkg::alu_or;
            core_pkg::op_xor:   op_3r = core_pkg::alu_xor;
            default:            is_3r = 1'b0;
        endcase
    end

    always_comb begin
        dec.pc      = pc;
        dec.a       = opnd_a;
        dec.b       = opnd_b;
        dec.rd      = inst[4:0];
        dec.imm     = {{20{inst[21]}}, inst[21:10]};
        dec.use_imm = is_addi || is_lu12i;
        dec.alu_op  = op_3r;
        // bit 26 tells bne from beq
        dec.br_ne   = inst[26];
        dec.branch  = inst_valid && is_branch;
        // unknown words fall through with no write
        dec.wr      = inst_valid && (is_3r || is_addi || is_lu12i);
        if (is_lu12i) begin
            dec.imm    = {inst[24:5], 12'd0};
            dec.alu_op = core_pkg::alu_pass_b;
        end else if (is_branch) begin
            dec.imm = {{14{inst[25]}}, inst[25:10], 2'b00};
        end
    end

endmodule : inst_decode

`default_nettype wire

//--- verilog/stage_reg.sv
`timescale 1ns/100ps
`default_nettype none

module stage_reg #(
    parameter type payload_t = logic
) (
    input  wire           clk,
    input  wire           rst,
    input  wire           stall,
    input  wire           flush,
    input  wire           in_valid,
    input  wire payload_t in_data,
    output logic          out_valid,
    output payload_t      out_data
);

    always_ff @(posedge clk) begin
        if (rst || flush) begin
            out_valid <= 1'b0;
        end else if (!stall) begin
            out_valid <= in_valid;
        end
    end

    // payload only moves with a valid entry
    always_ff @(posedge clk) begin
        if (!stall && in_valid) begin
            out_data <= in_data;
        end
    end

    no_stall_on_flush: assert property (@(posedge clk) disable iff (rst)
        !(flush && stall));

endmodule : stage_reg

`default_nettype wire

//--- verilog/execute_unit.sv
`timescale 1ns/100ps
`default_nettype none

module execute_unit (
    input  wire                     dec_valid,
    input  wire core_pkg::dec_pkt_t dec,
    output core_pkg::res_pkt_t      res,
    output logic                    flush,
    output core_pkg::word_t         redirect_pc,
    output core_pkg::word_t         ex_result
);

    core_pkg::word_t src_b;
    logic            taken;

    assign src_b = dec.use_imm ? dec.imm : dec.b;

    always_comb begin
        case (dec.alu_op)
            core_pkg::alu_add:    ex_result = dec.a + src_b;
            core_pkg::alu_sub:    ex_result = dec.a - src_b;
            core_pkg::alu_slt:    ex_result = {31'd0, $signed(dec.a) < $signed(src_b)};
            core_pkg::alu_and:    ex_result = dec.a & src_b;
            core_pkg::alu_or:     ex_result = dec.a | src_b;
            core_pkg::alu_xor:    ex_result = dec.a ^ src_b;
            core_pkg::alu_pass_b: ex_result = src_b;
            default:              ex_result = '0;
        endcase
    end

    // beq takes on equal, bne on not equal
    assign taken       = dec.branch && ((dec.a == dec.b) != dec.br_ne);
    assign flush       = dec_valid && taken;
    assign redirect_pc = dec.pc + dec.imm;

    // wr also drives the bypass, so squash it when the slot is empty
    always_comb begin
        res.pc     = dec.pc;
        res.rd     = dec.rd;
        res.wr     = dec_valid && dec.wr;
        res.result = ex_result;
    end

    // a taken branch must land on a word boundary
    always_comb begin
        redirect_aligned: assert (!flush || redirect_pc[1:0] == 2'b00);
    end

endmodule : execute_unit

`default_nettype wire

//--- verilog/write_back.sv
`timescale 1ns/100ps
`default_nettype none

module write_back (
    input  wire                     wb_valid,
    input  wire core_pkg::res_pkt_t res,
    output logic                    rf_we,
    output core_pkg::reg_addr_t     rf_waddr,
    output core_pkg::word_t         rf_wdata,
    output core_pkg::word_t         debug_wb_pc,
    output logic [3:0]              debug_wb_rf_wen,
    output core_pkg::reg_addr_t     debug_wb_rf_wnum,
    output core_pkg::word_t         debug_wb_rf_wdata
);

    // writes to r0 are dropped here
    assign rf_we    = wb_valid && res.wr && (res.rd != 5'd0);
    assign rf_waddr = res.rd;
    assign rf_wdata = res.result;

    // debug view mirrors the register write
    assign debug_wb_pc       = res.pc;
    assign debug_wb_rf_wen   = {4{rf_we}};
    assign debug_wb_rf_wnum  = res.rd;
    assign debug_wb_rf_wdata = res.result;

endmodule : write_back

`default_nettype wire

//--- verilog/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

module reg_file (
    input  wire                      clk,
    input  wire                      rst,
    input  wire core_pkg::reg_addr_t raddr1,
    input  wire core_pkg::reg_addr_t raddr2,
    output core_pkg::word_t          rdata1,
    output core_pkg::word_t          rdata2,
    input  wire                      we,
    input  wire core_pkg::reg_addr_t waddr,
    input  wire core_pkg::word_t     wdata
);

    core_pkg::word_t regs [32];

    always_ff @(posedge clk) begin
        if (rst) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // r0 reads zero whatever the array holds
    assign rdata1 = (raddr1 == 5'd0) ? '0 : regs[raddr1];
    assign rdata2 = (raddr2 == 5'd0) ? '0 : regs[raddr2];

    no_r0_write: assert property (@(posedge clk) disable iff (rst)
        we |-> waddr != 5'd0);

endmodule : reg_file

`default_nettype wire

//--- verilog/core.sv
`timescale 1ns/100ps
`default_nettype none

module core #(
    parameter core_pkg::word_t RESET_PC = 32'h1c00_0000
) (
    input  wire                  clk,
    input  wire                  rst,
    output logic                 iram_en,
    output core_pkg::word_t      iram_addr,
    input  wire core_pkg::word_t iram_rdata,
    input  wire                  iram_valid,
    output core_pkg::word_t      debug_wb_pc,
    output logic [3:0]           debug_wb_rf_wen,
    output core_pkg::reg_addr_t  debug_wb_rf_wnum,
    output core_pkg::word_t      debug_wb_rf_wdata
);

    logic                fetch_valid, flush;
    core_pkg::word_t     fetch_pc, redirect_pc, ex_result;
    logic                id_valid, ex_valid, wb_valid;
    logic [63:0]         id_data;
    core_pkg::dec_pkt_t  dec_pkt, ex_dec;
    core_pkg::res_pkt_t  ex_res, wb_res;
    core_pkg::reg_addr_t rf_raddr1, rf_raddr2, rf_waddr;
    core_pkg::word_t     rf_rdata1, rf_rdata2, rf_wdata;
    logic                rf_we;

    inst_fetch #(.RESET_PC(RESET_PC)) fetch_inst (
        .clk(clk), .rst(rst), .flush(flush), .redirect_pc(redirect_pc),
        .iram_valid(iram_valid), .iram_en(iram_en), .iram_addr(iram_addr),
        .fetch_valid(fetch_valid), .fetch_pc(fetch_pc)
    );

    // pc in the upper half, instruction word in the lower
    stage_reg #(.payload_t(logic [63:0])) if_id (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush),
        .in_valid(fetch_valid), .in_data({fetch_pc, iram_rdata}),
        .out_valid(id_valid), .out_data(id_data)
    );

    inst_decode decode_inst (
        .inst(id_data[31:0]), .pc(id_data[63:32]), .inst_valid(id_valid),
        .rf_raddr1(rf_raddr1), .rf_raddr2(rf_raddr2),
        .rf_rdata1(rf_rdata1), .rf_rdata2(rf_rdata2),
        .ex_valid(ex_res.wr), .ex_rd(ex_res.rd), .ex_result(ex_result),
        .wb_valid(rf_we), .wb_rd(rf_waddr), .wb_result(rf_wdata),
        .dec(dec_pkt)
    );

    stage_reg #(.payload_t(core_pkg::dec_pkt_t)) id_ex (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(flush),
        .in_valid(id_valid), .in_data(dec_pkt),
        .out_valid(ex_valid), .out_data(ex_dec)
    );

    execute_unit exec_inst (
        .dec_valid(ex_valid), .dec(ex_dec), .res(ex_res), .flush(flush),
        .redirect_pc(redirect_pc), .ex_result(ex_result)
    );

    // the branch itself always moves on to W
    stage_reg #(.payload_t(core_pkg::res_pkt_t)) ex_wb (
        .clk(clk), .rst(rst), .stall(1'b0), .flush(1'b0),
        .in_valid(ex_valid), .in_data(ex_res),
        .out_valid(wb_valid), .out_data(wb_res)
    );

    write_back wb_inst (
        .wb_valid(wb_valid), .res(wb_res),
        .rf_we(rf_we), .rf_waddr(rf_waddr), .rf_wdata(rf_wdata),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    reg_file rf_inst (
        .clk(clk), .rst(rst),
        .raddr1(rf_raddr1), .raddr2(rf_raddr2),
        .rdata1(rf_rdata1), .rdata2(rf_rdata2),
        .we(rf_we), .waddr(rf_waddr), .wdata(rf_wdata)
    );

endmodule : core

`default_nettype wire

//--- bench/core_tb.sv
`timescale 1ns/100ps
`default_nettype none

module core_tb;

    localparam core_pkg::word_t reset_pc = 32'h1c00_0000;
    localparam int prog_len = 27;
    // index of the last instruction that writes a register
    localparam int last_idx = 25;
    // about 40 words, x2 for fetch gaps, x4 for branch refetch, with wide margin
    localparam int cycle_limit = 2000;

    localparam int t_reset  = 0;
    localparam int t_alu    = 1;
    localparam int t_bypass = 2;
    localparam int t_branch = 3;
    localparam int t_r0     = 4;
    localparam int t_gaps   = 5;

    logic                clk = 1'b0;
    logic                rst;
    logic                iram_en;
    core_pkg::word_t     iram_addr;
    core_pkg::word_t     iram_rdata;
    logic                iram_valid;
    core_pkg::word_t     debug_wb_pc;
    logic [3:0]          debug_wb_rf_wen;
    core_pkg::reg_addr_t debug_wb_rf_wnum;
    core_pkg::word_t     debug_wb_rf_wdata;

    core_pkg::word_t prog [prog_len];
    core_pkg::word_t model_regs [32] = '{default: '0};
    core_pkg::word_t model_pc = reset_pc;
    string           test_label [6] = '{"reset_state", "alu_ops", "bypass",
                                        "branch_flush", "r0_and_nop", "fetch_gaps"};
    int              test_errs [6] = '{default: 0};
    integer          seed = 32'h6596_f13a;
    int              cycle_count = 0;
    int              gap_cycles = 0;
    int              pass_count = 0;
    int              fail_count = 0;
    int              stray_writes = 0;
    bit              done = 1'b0;

    core #(.RESET_PC(reset_pc)) core_inst (
        .clk(clk), .rst(rst), .iram_en(iram_en), .iram_addr(iram_addr),
        .iram_rdata(iram_rdata), .iram_valid(iram_valid),
        .debug_wb_pc(debug_wb_pc), .debug_wb_rf_wen(debug_wb_rf_wen),
        .debug_wb_rf_wnum(debug_wb_rf_wnum), .debug_wb_rf_wdata(debug_wb_rf_wdata)
    );

    always #50 clk = ~clk;

    // instruction encoders
    function automatic core_pkg::word_t enc_3r(logic [16:0] op, int rd, int rj, int rk);
        return {op, rk[4:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic core_pkg::word_t enc_addi(int rd, int rj, int imm);
        return {10'h00a, imm[11:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic core_pkg::word_t enc_lu12i(int rd, int imm);
        return {7'h0a, imm[19:0], rd[4:0]};
    endfunction

    function automatic core_pkg::word_t enc_br(logic [5:0] op, int rj, int rd, int offs);
        return {op, offs[15:0], rj[4:0], rd[4:0]};
    endfunction

    function automatic core_pkg::word_t rom_word(core_pkg::word_t addr);
        core_pkg::word_t offs;
        offs = addr - reset_pc;
        if (offs < 4 * prog_len && offs[1:0] == 2'b00) begin
            return prog[int'(offs >> 2)];
        end
        // top bits 6'h3f match no opcode class
        return {6'h3f, addr[25:0] ^ addr[31:6]};
    endfunction

    function automatic int test_of_index(int idx);
        if (idx <= 8) return t_alu;
        if (idx <= 13) return t_bypass;
        if (idx <= 21) return t_branch;
        return t_r0;
    endfunction

    function automatic core_pkg::word_t alu_3r(logic [16:0] op, core_pkg::word_t a,
                                               core_pkg::word_t b);
        case (op)
            17'h00020: return a + b;
            17'h00022: return a - b;
            17'h00024: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            17'h00029: return a & b;
            17'h0002a: return a | b;
            default:   return a ^ b;
        endcase
    endfunction

    // in-order model, steps to the next instruction that writes a register
    task automatic model_next_write(output bit found, output int idx,
                                    output core_pkg::word_t pc,
                                    output core_pkg::reg_addr_t rd,
                                    output core_pkg::word_t value);
        core_pkg::word_t inst;
        core_pkg::word_t a;
        core_pkg::word_t c;
        logic            wr;
        logic            taken;
        found = 1'b0;
        for (int step = 0; step < 8 && !found; step++) begin
            inst = rom_word(model_pc);
            pc = model_pc;
            idx = int'((model_pc - reset_pc) >> 2);
            rd = inst[4:0];
            a = model_regs[inst[9:5]];
            c = model_regs[inst[4:0]];
            wr = 1'b1;
            if (inst[31:15] inside {17'h20, 17'h22, 17'h24, 17'h29, 17'h2a, 17'h2b}) begin
                value = alu_3r(inst[31:15], a, model_regs[inst[14:10]]);
            end else if (inst[31:22] == 10'h00a) begin
                value = a + {{20{inst[21]}}, inst[21:10]};
            end else if (inst[31:25] == 7'h0a) begin
                value = {inst[24:5], 12'h000};
            end else begin
                wr = 1'b0;
            end
            taken = (inst[31:26] == 6'h16 && a == c) || (inst[31:26] == 6'h17 && a != c);
            if (taken) begin
                model_pc = model_pc + {{14{inst[25]}}, inst[25:10], 2'b00};
            end else begin
                model_pc = model_pc + 4;
            end
            // r0 writes behave as no-ops
            if (wr && rd != 5'd0) begin
                model_regs[rd] = value;
                found = 1'b1;
            end
        end
    endtask

    task automatic report_test(int t);
        if (test_errs[t] == 0) begin
            $display("PASS %s", test_label[t]);
            pass_count++;
        end else begin
            $display("FAIL %s, %0d errors", test_label[t], test_errs[t]);
            fail_count++;
        end
    endtask

    task automatic check_write();
        bit                  found;
        int                  idx;
        int                  t;
        core_pkg::word_t     pc;
        core_pkg::reg_addr_t rd;
        core_pkg::word_t     value;
        model_next_write(found, idx, pc, rd, value);
        if (!found) begin
            $display("** Error a write retired after the program end, pc %h", debug_wb_pc);
            stray_writes++;
        end else begin
            t = test_of_index(idx);
            assert (debug_wb_pc === pc) else begin
                $display("** Error %s pc: expected %h, actual %h", test_label[t], pc,
                         debug_wb_pc);
                test_errs[t]++;
                test_errs[t_gaps]++;
            end
            assert (debug_wb_rf_wnum === rd) else begin
                $display("** Error %s wnum: expected %0d, actual %0d", test_label[t], rd,
                         debug_wb_rf_wnum);
                test_errs[t]++;
                test_errs[t_gaps]++;
            end
            assert (debug_wb_rf_wdata === value) else begin
                $display("** Error %s wdata: expected %h, actual %h", test_label[t], value,
                         debug_wb_rf_wdata);
                test_errs[t]++;
                test_errs[t_gaps]++;
            end
            if (idx == last_idx || test_of_index(idx + 1) != t) begin
                report_test(t);
            end
            if (idx == last_idx) begin
                assert (gap_cycles > 0) else begin
                    $display("fetch_gaps: iram_valid never went low during the run");
                    test_errs[t_gaps]++;
                end
                report_test(t_gaps);
                done = 1'b1;
            end
        end
    endtask

    task automatic load_program();
        // alu_ops
        prog[0]  = enc_lu12i(1, 32'h12345);
        prog[1]  = enc_addi(2, 0, 32'h678);
        prog[2]  = enc_addi(3, 0, -5);
        prog[3]  = enc_3r(17'h20, 4, 1, 2);
        prog[4]  = enc_3r(17'h22, 5, 2, 3);
        prog[5]  = enc_3r(17'h24, 6, 3, 2);
        prog[6]  = enc_3r(17'h29, 7, 4, 3);
        prog[7]  = enc_3r(17'h2a, 8, 1, 2);
        prog[8]  = enc_3r(17'h2b, 9, 4, 1);
        // bypass at distance 1 and 2, then E ahead of W on r12
        prog[9]  = enc_addi(10, 9, 1);
        prog[10] = enc_3r(17'h20, 11, 10, 10);
        prog[11] = enc_3r(17'h22, 12, 11, 10);
        prog[12] = enc_addi(12, 12, 5);
        prog[13] = enc_3r(17'h2b, 13, 12, 11);
        // taken beq, taken bne, then an untaken beq
        prog[14] = enc_br(6'h16, 13, 13, 3);
        prog[15] = enc_addi(14, 0, 32'h111);
        prog[16] = enc_addi(14, 0, 32'h222);
        prog[17] = enc_br(6'h17, 13, 0, 3);
        prog[18] = enc_addi(15, 0, 32'h333);
        prog[19] = enc_addi(15, 0, 32'h444);
        prog[20] = enc_br(6'h16, 13, 0, 2);
        prog[21] = enc_addi(16, 13, 1);
        // r0 write read back at distance 1, an unknown word, final self loop
        prog[22] = enc_addi(0, 1, 32'h7ff);
        prog[23] = enc_3r(17'h2a, 17, 0, 1);
        prog[24] = 32'hffff_ffff;
        prog[25] = enc_3r(17'h20, 18, 0, 17);
        prog[26] = enc_br(6'h16, 0, 0, 0);
    endtask

    // memory answers 1 ns after the edge, with random gaps
    initial begin
        bit gap;
        iram_valid = 1'b0;
        iram_rdata = '0;
        forever begin
            @(posedge clk);
            #1;
            gap = ($random(seed) & 3) == 0;
            iram_valid = iram_en && !gap;
            iram_rdata = rom_word(iram_addr);
            // only random gaps on a live request count, not flush cycles
            if (cycle_count >= 4 && iram_en && gap) gap_cycles++;
        end
    end

    always @(posedge clk) begin
        cycle_count = cycle_count + 1;
        if (cycle_count > cycle_limit) begin
            $display("timeout: the program did not finish within %0d cycles", cycle_limit);
            $display("tests failed");
            $finish;
        end
    end

    always @(negedge clk) begin
        if (cycle_count >= 1 && cycle_count <= 4) begin
            assert (iram_en === 1'b1 && iram_addr === reset_pc && debug_wb_rf_wen === 4'h0)
            else begin
                $display("** Error reset_state: expected en 1 addr %h wen 0, actual %b %h %h",
                         reset_pc, iram_en, iram_addr, debug_wb_rf_wen);
                test_errs[t_reset]++;
            end
            if (cycle_count == 4) report_test(t_reset);
        end else if (!rst && debug_wb_rf_wen !== 4'h0) begin
            // strobe is all or nothing and never names r0
            assert (debug_wb_rf_wen === 4'hf && debug_wb_rf_wnum !== 5'd0) else begin
                $display("** Error r0_and_nop wen/wnum: expected f/nonzero, actual %h/%0d",
                         debug_wb_rf_wen, debug_wb_rf_wnum);
                test_errs[t_r0]++;
            end
            check_write();
        end
    end

    initial begin
        rst = 1'b1;
        load_program();
        repeat (4) @(posedge clk);
        #1;
        rst = 1'b0;
        wait (done);
        // closing self loop must retire nothing
        repeat (20) @(posedge clk);
        $display("summary: passed %0d, failed %0d, stray writes %0d",
                 pass_count, fail_count, stray_writes);
        if (pass_count == 6 && fail_count == 0 && stray_writes == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule : core_tb

`default_nettype wire

//--- compile.f
verilog/core_pkg.sv
verilog/inst_fetch.sv
verilog/operand_bypass.sv
verilog/inst_decode.sv
verilog/stage_reg.sv
verilog/execute_unit.sv
verilog/write_back.sv
verilog/reg_file.sv
verilog/core.sv
bench/core_tb.sv

//--- Makefile
# Verilator build and run for the core testbench

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert --top-module core_tb -f compile.f

obj_dir/core_tb: compile.f verilog/*.sv bench/core_tb.sv
	verilator --binary --timing --assert --top-module core_tb -f compile.f \
		--Mdir obj_dir -o core_tb

sim: obj_dir/core_tb
	./obj_dir/core_tb > sim.log 2>&1; cat sim.log
	@if grep -q "tests failed" sim.log; then \
		echo "simulation reported failure"; exit 1; \
	fi
	@if ! grep -q "all tests passed" sim.log; then \
		echo "simulation ended without a result"; exit 1; \
	fi

clean:
	rm -rf obj_dir sim.log
